// File: design/fp_format_pkg.sv
/*
 * Binary32 format definitions
 * Field widths, the packed operand layout, per-operand classification
 * flags, the exception status word and the one-hot FCLASS mask
 */
package fp_format_pkg;

  // --------------------------------------------------------------------------
  // Format widths
  // --------------------------------------------------------------------------
  localparam int unsigned fp_width_p  = 32;
  localparam int unsigned exp_bits_p  = 8;
  localparam int unsigned man_bits_p  = 23;

  // Operand layout, sign in the top bit
  typedef struct packed {
    logic                  sign;
    logic [exp_bits_p-1:0] exponent;
    logic [man_bits_p-1:0] mantissa;
  } fp_t;

  // Quiet NaN with positive sign and only the top mantissa bit set
  localparam fp_t canonical_nan_p = 32'h7fc0_0000;

  // Kind of one operand, exactly one of the first five is set
  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // IEEE 754 exception flags, NV in the top bit
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } fp_status_t;

  // FCLASS result, one bit per class
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } class_mask_e;

endpackage

// File: design/noncomp_op_pkg.sv
/*
 * Opcodes of the non-computational FP unit
 * Opcode enum plus helpers that sort an opcode into its group
 */
package noncomp_op_pkg;

  localparam int unsigned op_width_p = 4;

  typedef enum logic [op_width_p-1:0] {
    OP_SGNJ   = 4'd0,
    OP_SGNJN  = 4'd1,
    OP_SGNJX  = 4'd2,
    OP_MIN    = 4'd3,
    OP_MAX    = 4'd4,
    OP_FLE    = 4'd5,
    OP_FLT    = 4'd6,
    OP_FEQ    = 4'd7,
    OP_FCLASS = 4'd8
  } noncomp_op_e;

  // --------------------------------------------------------------------------
  // Group helpers
  // --------------------------------------------------------------------------
  function automatic logic is_sgnj_op(noncomp_op_e op);
    return op inside {OP_SGNJ, OP_SGNJN, OP_SGNJX};
  endfunction

  function automatic logic is_minmax_op(noncomp_op_e op);
    return op inside {OP_MIN, OP_MAX};
  endfunction

  function automatic logic is_cmp_op(noncomp_op_e op);
    return op inside {OP_FLE, OP_FLT, OP_FEQ};
  endfunction

  // Any encoding the unit knows, codes 9 to 15 are unused
  function automatic logic is_valid_op(noncomp_op_e op);
    return is_sgnj_op(op) | is_minmax_op(op) | is_cmp_op(op) | (op == OP_FCLASS);
  endfunction

endpackage

// File: design/fp_classifier.sv
/*
 * Binary32 operand classifier
 * Sorts each of two operands into zero, subnormal, normal, infinity
 * or NaN and marks signalling NaNs
 */
`timescale 1ns/1ps

module fp_classifier
  import fp_format_pkg::*;
(
  input  fp_t      [1:0] operands_i,
  output fp_info_t [1:0] info_o
);

  for (genvar i = 0; i < 2; i++) begin : gen_operand
    logic exp_zero;
    logic exp_max;
    logic man_zero;
    logic is_nan;

    // Exponent field all zeros or all ones
    assign exp_zero = (operands_i[i].exponent == '0);
    assign exp_max  = (operands_i[i].exponent == {exp_bits_p{1'b1}});
    assign man_zero = (operands_i[i].mantissa == '0);

    // Max exponent with any payload
    assign is_nan = exp_max & ~man_zero;

    assign info_o[i] = '{
      is_zero:       exp_zero & man_zero,
      is_subnormal:  exp_zero & ~man_zero,
      is_normal:     ~exp_zero & ~exp_max,
      is_inf:        exp_max & man_zero,
      is_nan:        is_nan,
      // Quiet bit clear marks a signalling NaN
      is_signalling: is_nan & ~operands_i[i].mantissa[man_bits_p-1]
    };
  end

endmodule

// File: design/pipe_stage.sv
/*
 * Valid/ready register chain
 * NumRegs enable-register stages with synchronous flush, carrying one
 * flat data word; zero stages give a combinational path
 */
`timescale 1ns/1ps

module pipe_stage #(
  parameter int unsigned NumRegs   = 1,
  parameter int unsigned DataWidth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  // Upstream side
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [DataWidth-1:0] in_data_i,
  // Downstream side
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [DataWidth-1:0] out_data_o,
  // Any stage holds an item
  output logic                 busy_o
);

  // Index i is the view after i stages, index 0 is the input
  logic [NumRegs:0]                valid;
  logic [NumRegs:0]                ready;
  logic [NumRegs:0][DataWidth-1:0] data;

  assign valid[0]   = in_valid_i;
  assign data[0]    = in_data_i;
  assign in_ready_o = ready[0];

  // --------------------------------------------------------------------------
  // Register stages
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic                 valid_q;
    logic [DataWidth-1:0] data_q;
    logic                 load;

    // Take a new item when the next stage takes ours or we hold a bubble
    assign ready[i] = ready[i+1] | ~valid_q;
    // Payload only moves with a valid item
    assign load     = ready[i] & valid[i];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else if (flush_i) begin
        valid_q <= 1'b0;
      end else if (ready[i]) begin
        valid_q <= valid[i];
      end
    end

    // No reset on payload
    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q <= data[i];
      end
    end

    assign valid[i+1] = valid_q;
    assign data[i+1]  = data_q;
  end

  // Last stage sees the sink directly
  assign ready[NumRegs] = out_ready_i;
  assign out_valid_o    = valid[NumRegs];
  assign out_data_o     = data[NumRegs];

  if (NumRegs == 0) begin : gen_no_busy
    assign busy_o = 1'b0;
  end else begin : gen_busy
    assign busy_o = |valid[NumRegs:1];
  end

  // A stalled item must not change under the sink
  a_out_data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> $stable(out_data_o))
    else $error("pipe_stage: output data changed while stalled");

endmodule

// File: design/fp_noncomp_ops.sv
/*
 * Non-computational binary32 operations
 * Sign injection, min/max, LE/LT/EQ comparison and FCLASS, followed
 * by result and flag selection on the opcode
 */
`timescale 1ns/1ps

module fp_noncomp_ops
  import fp_format_pkg::*;
  import noncomp_op_pkg::*;
(
  input  fp_t         operand_a_i,
  input  fp_t         operand_b_i,
  input  fp_info_t    info_a_i,
  input  fp_info_t    info_b_i,
  input  noncomp_op_e op_i,
  output fp_t         result_o,
  output fp_status_t  status_o
);

  // --------------------------------------------------------------------------
  // Shared operand relations
  // --------------------------------------------------------------------------
  logic any_nan;
  logic any_snan;
  logic ops_equal;
  logic a_smaller;

  assign any_nan  = info_a_i.is_nan | info_b_i.is_nan;
  assign any_snan = info_a_i.is_signalling | info_b_i.is_signalling;

  // Bitwise match, or +0 against -0
  assign ops_equal = (operand_a_i == operand_b_i) | (info_a_i.is_zero & info_b_i.is_zero);

  // Sign-magnitude order from an unsigned compare
  // Flipped when a negative sign is involved, so -0 lands below +0
  assign a_smaller = (operand_a_i < operand_b_i) ^ (operand_a_i.sign | operand_b_i.sign);

  // --------------------------------------------------------------------------
  // Sign injection
  // --------------------------------------------------------------------------
  fp_t sgnj_result;

  always_comb begin
    // Magnitude always from A
    sgnj_result = operand_a_i;
    case (op_i)
      OP_SGNJN: sgnj_result.sign = ~operand_b_i.sign;
      OP_SGNJX: sgnj_result.sign = operand_a_i.sign ^ operand_b_i.sign;
      default:  sgnj_result.sign = operand_b_i.sign;
    endcase
  end

  // --------------------------------------------------------------------------
  // Minimum and maximum
  // --------------------------------------------------------------------------
  fp_t        minmax_result;
  fp_status_t minmax_status;

  always_comb begin
    minmax_status    = '0;
    // Quiet operation, only sNaN is invalid
    minmax_status.NV = any_snan;
    if (info_a_i.is_nan && info_b_i.is_nan) begin
      minmax_result = canonical_nan_p;
    end else if (info_a_i.is_nan) begin
      minmax_result = operand_b_i;
    end else if (info_b_i.is_nan) begin
      minmax_result = operand_a_i;
    end else if (op_i == OP_MAX) begin
      minmax_result = a_smaller ? operand_b_i : operand_a_i;
    end else begin
      minmax_result = a_smaller ? operand_a_i : operand_b_i;
    end
  end

  // --------------------------------------------------------------------------
  // Comparisons
  // --------------------------------------------------------------------------
  logic       cmp_bit;
  fp_status_t cmp_status;

  always_comb begin
    cmp_bit    = 1'b0;
    cmp_status = '0;
    if (any_snan) begin
      // sNaN is always invalid and compares false
      cmp_status.NV = 1'b1;
    end else begin
      case (op_i)
        OP_FLE: begin
          // Signalling compare, any NaN is invalid
          if (any_nan) cmp_status.NV = 1'b1;
          else         cmp_bit = a_smaller | ops_equal;
        end
        OP_FLT: begin
          if (any_nan) cmp_status.NV = 1'b1;
          else         cmp_bit = a_smaller & ~ops_equal;
        end
        default: begin
          // FEQ is quiet, qNaN just gives false
          cmp_bit = ~any_nan & ops_equal;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Classification of operand A
  // --------------------------------------------------------------------------
  class_mask_e class_mask;

  always_comb begin
    if (info_a_i.is_normal) begin
      class_mask = operand_a_i.sign ? NEGNORM : POSNORM;
    end else if (info_a_i.is_subnormal) begin
      class_mask = operand_a_i.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_a_i.is_zero) begin
      class_mask = operand_a_i.sign ? NEGZERO : POSZERO;
    end else if (info_a_i.is_inf) begin
      class_mask = operand_a_i.sign ? NEGINF : POSINF;
    end else begin
      class_mask = info_a_i.is_signalling ? SNAN : QNAN;
    end
  end

  // --------------------------------------------------------------------------
  // Result selection
  // --------------------------------------------------------------------------
  always_comb begin
    if (is_sgnj_op(op_i)) begin
      result_o = sgnj_result;
      status_o = '0;
    end else if (is_minmax_op(op_i)) begin
      result_o = minmax_result;
      status_o = minmax_status;
    end else if (is_cmp_op(op_i)) begin
      // Boolean in bit 0
      result_o = fp_t'(fp_width_p'(cmp_bit));
      status_o = cmp_status;
    end else begin
      // Mask zero-extended, no flags
      result_o = fp_t'(fp_width_p'(class_mask));
      status_o = '0;
    end
  end

endmodule

// File: design/fp_noncomp_top.sv
/*
 * Non-computational binary32 FP unit
 * Input register chain, classifier and operation logic, then output
 * register chain, all under one valid/ready handshake with flush
 */
`timescale 1ns/1ps

module fp_noncomp_top
  import fp_format_pkg::*;
  import noncomp_op_pkg::*;
#(
  parameter int unsigned TagWidth   = 4,
  parameter int unsigned NumInRegs  = 1,
  parameter int unsigned NumOutRegs = 1
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  // Operation in
  input  fp_t                   operand_a_i,
  input  fp_t                   operand_b_i,
  input  noncomp_op_e           op_i,
  input  logic [TagWidth-1:0]   tag_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  // Result out
  output logic [fp_width_p-1:0] result_o,
  output fp_status_t            status_o,
  output logic [TagWidth-1:0]   tag_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  localparam int unsigned status_width_p = $bits(fp_status_t);
  // Input word {op, tag, B, A}, output word {tag, status, result}
  localparam int unsigned in_width_p  = 2 * fp_width_p + op_width_p + TagWidth;
  localparam int unsigned out_width_p = fp_width_p + status_width_p + TagWidth;

  logic [in_width_p-1:0]  in_word;
  logic [in_width_p-1:0]  stage_word;
  logic [out_width_p-1:0] res_word;
  logic [out_width_p-1:0] out_word;
  logic                   stage_valid;
  logic                   stage_ready;
  logic                   in_busy;
  logic                   out_busy;
  fp_t      [1:0]         stage_operands;
  noncomp_op_e            stage_op;
  logic [TagWidth-1:0]    stage_tag;
  fp_info_t [1:0]         stage_info;
  fp_t                    ops_result;
  fp_status_t             ops_status;

  // --------------------------------------------------------------------------
  // Input stages
  // --------------------------------------------------------------------------
  assign in_word = {op_i, tag_i, operand_b_i, operand_a_i};

  pipe_stage #(
    .NumRegs   (NumInRegs),
    .DataWidth (in_width_p)
  ) u_in_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_word),
    .out_valid_o (stage_valid),
    .out_ready_i (stage_ready),
    .out_data_o  (stage_word),
    .busy_o      (in_busy)
  );

  // Operand A sits at index 0
  assign stage_operands = stage_word[2*fp_width_p-1:0];
  assign stage_tag      = stage_word[2*fp_width_p +: TagWidth];
  assign stage_op       = noncomp_op_e'(stage_word[in_width_p-1 -: op_width_p]);

  fp_classifier u_classifier (
    .operands_i (stage_operands),
    .info_o     (stage_info)
  );

  fp_noncomp_ops u_ops (
    .operand_a_i (stage_operands[0]),
    .operand_b_i (stage_operands[1]),
    .info_a_i    (stage_info[0]),
    .info_b_i    (stage_info[1]),
    .op_i        (stage_op),
    .result_o    (ops_result),
    .status_o    (ops_status)
  );

  // --------------------------------------------------------------------------
  // Output stages
  // --------------------------------------------------------------------------
  assign res_word = {stage_tag, ops_status, ops_result};

  pipe_stage #(
    .NumRegs   (NumOutRegs),
    .DataWidth (out_width_p)
  ) u_out_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (stage_valid),
    .in_ready_o  (stage_ready),
    .in_data_i   (res_word),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_word),
    .busy_o      (out_busy)
  );

  assign result_o = out_word[fp_width_p-1:0];
  assign status_o = fp_status_t'(out_word[fp_width_p +: status_width_p]);
  assign tag_o    = out_word[out_width_p-1 -: TagWidth];
  assign busy_o   = in_busy | out_busy;

  // Item reaching the ops must carry a known opcode
  a_defined_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stage_valid |-> is_valid_op(stage_op))
    else $error("fp_noncomp_top: undefined opcode %0d in flight", stage_op);

endmodule

// File: tb/tb_fp_noncomp.sv
/*
 * Testbench for the non-computational binary32 FP unit
 * Replays the stimulus file under random back-pressure, then checks
 * the state after reset and the effect of a flush
 */
`timescale 1ns/1ps

module tb_fp_noncomp
  import fp_format_pkg::*;
  import noncomp_op_pkg::*;
();

  localparam int unsigned ClkPeriod      = 20;
  localparam int unsigned TagWidth       = 4;
  localparam int unsigned NumVectors     = 38;
  // Opcode, A, B, expected result, expected NV
  localparam int unsigned VecWords       = 5;
  localparam int unsigned WatchdogCycles = NumVectors * 40 + 200;
  // Queue entry {tag, nv, result}
  localparam int unsigned ExpWidth       = TagWidth + 1 + fp_width_p;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  flush_i;
  fp_t                   operand_a_i;
  fp_t                   operand_b_i;
  noncomp_op_e           op_i;
  logic [TagWidth-1:0]   tag_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic [fp_width_p-1:0] result_o;
  fp_status_t            status_o;
  logic [TagWidth-1:0]   tag_o;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  busy_o;

  logic [31:0]         vec_mem [NumVectors*VecWords];
  logic [ExpWidth-1:0] exp_q[$];
  logic [31:0]         lcg_state;
  int                  pass_count;
  int                  fail_count;

  fp_noncomp_top #(
    .TagWidth   (TagWidth),
    .NumInRegs  (1),
    .NumOutRegs (1)
  ) u_fp_noncomp_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("Test %s finished with %0d error(s)", name, fail_count - fails_before);
  endtask

  // Put one stimulus line on the input side, tag is the line index
  task automatic present_vector(input int idx);
    op_i        = noncomp_op_e'(vec_mem[VecWords*idx][op_width_p-1:0]);
    operand_a_i = vec_mem[VecWords*idx+1];
    operand_b_i = vec_mem[VecWords*idx+2];
    tag_i       = idx[TagWidth-1:0];
    in_valid_i  = 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // Stream test
  // --------------------------------------------------------------------------
  task automatic drive_vectors();
    for (int i = 0; i < NumVectors; i++) begin
      present_vector(i);
      exp_q.push_back({i[TagWidth-1:0], vec_mem[VecWords*i+4][0], vec_mem[VecWords*i+3]});
      // Hold until the DUT takes it
      do @(posedge clk_i); while (!in_ready_o);
      #2;
    end
    in_valid_i = 1'b0;
  endtask

  task automatic monitor_results();
    logic [ExpWidth-1:0] exp_item;
    int                  received;
    received = 0;
    while (received < NumVectors) begin
      @(posedge clk_i);
      // Input may only stall behind a stalled output
      if (!in_ready_o && !(out_valid_o && !out_ready_i)) begin
        $display("Input side stalled at %0t ns although the output could move", $time);
        fail_count++;
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Output transfer at %0t ns with no operation outstanding", $time);
          fail_count++;
        end else begin
          exp_item = exp_q.pop_front();
          if (tag_o !== exp_item[ExpWidth-1 -: TagWidth]) begin
            $display("Tag %0d came out at %0t ns while tag %0d was due, order is broken",
                     tag_o, $time, exp_item[ExpWidth-1 -: TagWidth]);
            fail_count++;
          end else begin
            pass_count++;
          end
          check_value("result_o", exp_item[fp_width_p-1:0], result_o);
          // Only NV can ever be raised by this unit
          check_value("status_o", {exp_item[fp_width_p], 4'b0000}, status_o);
        end
        received++;
      end
      #2;
      // Sink readiness from the LCG, about half the cycles
      lcg_state   = lcg_next(lcg_state);
      out_ready_i = lcg_state[31];
    end
  endtask

  // --------------------------------------------------------------------------
  // Flush test
  // --------------------------------------------------------------------------
  task automatic run_flush_test();
    // Sink held off so both items stay in the pipe
    out_ready_i = 1'b0;
    for (int i = 0; i < 2; i++) begin
      present_vector(i);
      do @(posedge clk_i); while (!in_ready_o);
      #2;
    end
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(posedge clk_i);
    // Both items still held when the flush edge arrives
    check_value("busy_o before flush", 1, busy_o);
    #2;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    @(posedge clk_i);
    check_value("busy_o after flush", 0, busy_o);
    check_value("out_valid_o after flush", 0, out_valid_o);
    // Dropped items must never appear
    repeat (4) begin
      if (out_valid_o && out_ready_i) begin
        $display("Output transfer at %0t ns after the flush", $time);
        fail_count++;
      end
      @(posedge clk_i);
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int fails_before;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = OP_SGNJ;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    pass_count  = 0;
    fail_count  = 0;
    lcg_state   = 32'h5985_3c9f;
    $readmemh("tb/stimulus_noncomp.txt", vec_mem);

    repeat (8) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    fails_before = fail_count;
    @(posedge clk_i);
    check_value("out_valid_o after reset", 0, out_valid_o);
    check_value("busy_o after reset", 0, busy_o);
    check_value("in_ready_o after reset", 1, in_ready_o);
    report_test("reset", fails_before);

    fails_before = fail_count;
    #2;
    fork
      drive_vectors();
      monitor_results();
    join
    report_test("vectors", fails_before);

    fails_before = fail_count;
    run_flush_test();
    report_test("flush", fails_before);

    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized from the number of stimulus lines
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout after %0d cycles, the run never reached its end", WatchdogCycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: fp_noncomp.f
design/fp_format_pkg.sv
design/noncomp_op_pkg.sv
design/fp_classifier.sv
design/pipe_stage.sv
design/fp_noncomp_ops.sv
design/fp_noncomp_top.sv
tb/tb_fp_noncomp.sv

// File: Bender.yml
package:
  name: fp_noncomp

sources:
  # Packages first, they are imported by the RTL
  - design/fp_format_pkg.sv
  - design/noncomp_op_pkg.sv
  # RTL, leaves before the top level
  - design/fp_classifier.sv
  - design/pipe_stage.sv
  - design/fp_noncomp_ops.sv
  - design/fp_noncomp_top.sv
  # Testbench
  - target: test
    files:
      - tb/tb_fp_noncomp.sv

// File: tb/stimulus_noncomp.txt
// opcode operand_a operand_b expected_result expected_nv (all hex)
// opcodes 0 SGNJ 1 SGNJN 2 SGNJX 3 MIN 4 MAX 5 FLE 6 FLT 7 FEQ 8 FCLASS
0 3f800000 bf800000 bf800000 0
1 3f800000 3f800000 bf800000 0
1 80000000 80000000 00000000 0
2 bf800000 bf800000 3f800000 0
2 7f800000 80000000 ff800000 0
0 7fc00000 80000000 ffc00000 0
2 ff800001 40000000 ff800001 0
3 3f800000 40000000 3f800000 0
4 3f800000 40000000 40000000 0
3 c0000000 bf800000 c0000000 0
4 c0000000 3f800000 3f800000 0
3 00000000 80000000 80000000 0
4 80000000 00000000 00000000 0
3 7fc00000 3f800000 3f800000 0
4 bf800000 7fc00000 bf800000 0
3 7fc00000 ffc00000 7fc00000 0
4 7f800001 3f800000 3f800000 1
5 3f800000 3f800000 00000001 0
6 3f800000 3f800000 00000000 0
7 00000000 80000000 00000001 0
6 80000000 00000000 00000000 0
5 80000000 00000000 00000001 0
6 c0000000 bf800000 00000001 0
5 bf800000 c0000000 00000000 0
7 7fc00000 7fc00000 00000000 0
5 7fc00000 3f800000 00000000 1
6 3f800000 ffc00000 00000000 1
7 7f800001 3f800000 00000000 1
8 ff800000 00000000 00000001 0
8 bf800000 00000000 00000002 0
8 80000001 00000000 00000004 0
8 80000000 00000000 00000008 0
8 00000000 00000000 00000010 0
8 00400000 00000000 00000020 0
8 3f800000 00000000 00000040 0
8 7f800000 00000000 00000080 0
8 7f800001 00000000 00000100 0
8 7fc00000 00000000 00000200 0
